// File: bench/datapath_tb.sv
`default_nettype none

`include "mips_macros.svh"

module datapath_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_WORDS  = 64;
    localparam int CYCLE_LIMIT = 1000;

    logic                   clk;
    logic                   rst_n;
    mips_pkg::ibus_req_t    imem_req;
    mips_pkg::ibus_resp_t   imem_resp;
    logic                   retire_valid;
    logic                   retire_ready;
    mips_pkg::retire_data_t retire;

    mips_pkg::word_t imem [PROG_WORDS];
    mips_pkg::word_t ref_regs [32];
    mips_pkg::word_t next_fetch_pc;
    integer          seed;
    int              retired;
    int              cycles = 0;

    datapath DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_req     (imem_req),
        .imem_resp    (imem_resp),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(string test, mips_pkg::word_t expv, mips_pkg::word_t actv);
        $display("Fail %s expected %h actual %h", test, expv, actv);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_error(string what);
        $display("Error: %s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic mips_pkg::word_t encode_rtype(int rs, int rt, int rd, logic [5:0] fn);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t encode_itype(logic [5:0] op, int rs, int rt,
                                                     logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // reference model that applies one instruction and returns the expected write
    function automatic mips_pkg::rf_w_t model_step(mips_pkg::word_t instr);
        mips_pkg::rf_w_t w;
        mips_pkg::word_t a;
        mips_pkg::word_t b;
        logic            known;
        a      = ref_regs[instr[25:21]];
        b      = ref_regs[instr[20:16]];
        known  = 1'b1;
        w      = '0;
        w.addr = instr[20:16];
        case (instr[31:26])
            `OP_SPECIAL: begin
                w.addr = instr[15:11];
                case (instr[5:0])
                    `FN_ADDU: w.data = a + b;
                    `FN_SUBU: w.data = a - b;
                    `FN_AND:  w.data = a & b;
                    `FN_OR:   w.data = a | b;
                    `FN_XOR:  w.data = a ^ b;
                    `FN_SLT:  w.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  known = 1'b0;
                endcase
            end
            `OP_ADDIU: w.data = a + {{16{instr[15]}}, instr[15:0]};
            `OP_ORI:   w.data = a | {16'h0000, instr[15:0]};
            `OP_LUI:   w.data = {instr[15:0], 16'h0000};
            default:   known = 1'b0;
        endcase
        w.wen = known && (w.addr != 5'd0);
        if (w.wen) begin
            ref_regs[w.addr] = w.data;
        end
        return w;
    endfunction

    task automatic build_program();
        int          sel;
        int          rs;
        int          rt;
        int          rd;
        logic [15:0] imm;
        // fixed part where each instruction mostly reads the one before
        imem[0]  = encode_itype(`OP_LUI, 0, 1, 16'h8000);
        imem[1]  = encode_itype(`OP_ORI, 1, 1, 16'hffff);
        imem[2]  = encode_itype(`OP_ADDIU, 0, 2, 16'hfffb);
        imem[3]  = encode_itype(`OP_ADDIU, 2, 3, 16'h0007);
        imem[4]  = encode_rtype(2, 3, 4, `FN_SLT);
        imem[5]  = encode_rtype(3, 2, 5, `FN_SLT);
        imem[6]  = encode_rtype(1, 3, 6, `FN_ADDU);
        imem[7]  = encode_rtype(3, 2, 7, `FN_SUBU);
        imem[8]  = encode_rtype(1, 2, 8, `FN_AND);
        imem[9]  = encode_rtype(2, 3, 9, `FN_OR);
        imem[10] = encode_rtype(1, 2, 10, `FN_XOR);
        // disabled writes to $zero and from unknown encodings
        imem[11] = encode_rtype(1, 2, 0, `FN_ADDU);
        imem[12] = encode_itype(`OP_ADDIU, 0, 0, 16'h0005);
        imem[13] = 32'hfc000000;
        imem[14] = encode_rtype(1, 2, 3, 6'h3f);
        imem[15] = encode_rtype(0, 0, 11, `FN_ADDU);
        imem[16] = encode_rtype(0, 1, 12, `FN_OR);
        for (int i = 17; i < PROG_WORDS; i++) begin
            sel = ($random(seed) & 32'h7fff) % 10;
            rs  = $random(seed) & 15;
            rt  = $random(seed) & 15;
            rd  = $random(seed) & 15;
            imm = 16'($random(seed));
            case (sel)
                0: imem[i] = encode_rtype(rs, rt, rd, `FN_ADDU);
                1: imem[i] = encode_rtype(rs, rt, rd, `FN_SUBU);
                2: imem[i] = encode_rtype(rs, rt, rd, `FN_AND);
                3: imem[i] = encode_rtype(rs, rt, rd, `FN_OR);
                4: imem[i] = encode_rtype(rs, rt, rd, `FN_XOR);
                5: imem[i] = encode_rtype(rs, rt, rd, `FN_SLT);
                6: imem[i] = encode_itype(`OP_ADDIU, rs, rt, imm);
                7: imem[i] = encode_itype(`OP_ORI, rs, rt, imm);
                8: imem[i] = encode_itype(`OP_LUI, 0, rt, imm);
                default: imem[i] = {6'h3f, 26'($random(seed))};
            endcase
        end
    endtask

    function automatic mips_pkg::word_t fetch_word(mips_pkg::word_t addr);
        mips_pkg::word_t offset;
        offset = (addr - `RESET_PC) >> 2;
        // past the program each word reads as its own address
        if (offset < PROG_WORDS) begin
            return imem[offset[5:0]];
        end
        return addr;
    endfunction

    task automatic check_retire();
        mips_pkg::word_t exp_pc;
        mips_pkg::word_t instr;
        mips_pkg::rf_w_t exp_w;
        string           name;
        exp_pc = `RESET_PC + 32'(retired * 4);
        instr  = imem[retired];
        name   = $sformatf("retire %0d (instr %h)", retired, instr);
        exp_w  = model_step(instr);
        assert (retire.pc == exp_pc)
            else report_mismatch({name, " pc"}, exp_pc, retire.pc);
        assert (retire.rfw.wen == exp_w.wen)
            else report_mismatch({name, " wen"}, 32'(exp_w.wen), 32'(retire.rfw.wen));
        if (exp_w.wen) begin
            assert (retire.rfw.addr == exp_w.addr)
                else report_mismatch({name, " addr"}, 32'(exp_w.addr), 32'(retire.rfw.addr));
            assert (retire.rfw.data == exp_w.data)
                else report_mismatch({name, " data"}, exp_w.data, retire.rfw.data);
        end
        retired++;
    endtask

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !retire_valid && !imem_req.valid)
        else report_error("retire_valid or imem_req.valid high during reset");

    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req.valid && !imem_resp.addr_ok |=> imem_req.valid && $stable(imem_req.addr))
        else report_error("imem request dropped or changed before addr_ok");

    retire_hold: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
        else report_error("retire record dropped or changed while stalled");

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            report_error("timeout, the program did not retire within the cycle limit");
        end
    end

    // memory model and retire sink driven on the falling edge
    initial begin
        int              addr_wait;
        int              data_wait;
        logic            busy;
        mips_pkg::word_t pend_addr;
        busy      = 1'b0;
        pend_addr = '0;
        data_wait = 0;
        wait (rst_n);
        addr_wait = ($random(seed) & 32'hff) % 3;
        forever begin
            @(negedge clk);
            imem_resp.addr_ok = 1'b0;
            imem_resp.data_ok = 1'b0;
            // sparse ready in the second half backs up both queues into fetch
            if (retired < PROG_WORDS / 2) begin
                retire_ready = ($random(seed) & 3) != 0;
            end else begin
                retire_ready = ($random(seed) & 7) == 0;
            end
            if (!busy && imem_req.valid) begin
                if (addr_wait == 0) begin
                    assert (imem_req.addr == next_fetch_pc)
                        else report_mismatch("fetch address", next_fetch_pc, imem_req.addr);
                    next_fetch_pc    += 4;
                    pend_addr         = imem_req.addr;
                    imem_resp.addr_ok = 1'b1;
                    data_wait         = 1 + (($random(seed) & 32'hff) % 3);
                    busy              = 1'b1;
                end else begin
                    addr_wait--;
                end
            end else if (busy) begin
                data_wait--;
                if (data_wait == 0) begin
                    imem_resp.data_ok = 1'b1;
                    imem_resp.data    = fetch_word(pend_addr);
                    addr_wait         = ($random(seed) & 32'hff) % 3;
                    busy              = 1'b0;
                end
            end
            // the record shown now is taken at the next rising edge
            if (retire_valid && retire_ready && retired < PROG_WORDS) begin
                check_retire();
            end
        end
    end

    initial begin
        seed          = 32'h8805;
        rst_n         = 1'b0;
        retire_ready  = 1'b0;
        imem_resp     = '0;
        retired       = 0;
        next_fetch_pc = `RESET_PC;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        build_program();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        wait (retired == PROG_WORDS);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`default_nettype none

`include "mips_macros.svh"

module datapath (
    input  logic                   clk,
    input  logic                   rst_n,
    output mips_pkg::ibus_req_t    imem_req,
    input  mips_pkg::ibus_resp_t   imem_resp,
    output logic                   retire_valid,
    input  logic                   retire_ready,
    output mips_pkg::retire_data_t retire
);

    // fetch to fetch queue
    logic                   f_valid;
    logic                   f_ready;
    mips_pkg::fetch_data_t  f_data;
    // fetch queue to execute
    logic                   x_valid;
    logic                   x_ready;
    mips_pkg::fetch_data_t  x_data;
    // execute to retire queue
    logic                   r_valid;
    logic                   r_ready;
    mips_pkg::retire_data_t r_data;

    fetch fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_req  (imem_req),
        .imem_resp (imem_resp),
        .out_valid (f_valid),
        .out_ready (f_ready),
        .out_data  (f_data)
    );

    pipe_fifo #(
        .DEPTH     (`FQ_DEPTH),
        .payload_t (mips_pkg::fetch_data_t)
    ) fetch_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (f_valid),
        .in_ready  (f_ready),
        .in_data   (f_data),
        .out_valid (x_valid),
        .out_ready (x_ready),
        .out_data  (x_data)
    );

    execute execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (x_valid),
        .in_ready  (x_ready),
        .in_data   (x_data),
        .out_valid (r_valid),
        .out_ready (r_ready),
        .out_data  (r_data)
    );

    pipe_fifo #(
        .DEPTH     (`RQ_DEPTH),
        .payload_t (mips_pkg::retire_data_t)
    ) retire_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (r_data),
        .out_valid (retire_valid),
        .out_ready (retire_ready),
        .out_data  (retire)
    );

endmodule

`default_nettype wire

// File: rtl/decode.sv
`default_nettype none

`include "mips_macros.svh"

module decode (
    input  mips_pkg::word_t        instr,
    output mips_pkg::decode_data_t out
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        out.rs       = instr[25:21];
        out.rt       = instr[20:16];
        out.imm      = instr[15:0];
        out.alu_op   = mips_pkg::ALU_NONE;
        out.dst      = '0;
        out.use_imm  = 1'b0;
        out.zero_ext = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                // R-type writes rd
                out.dst = instr[15:11];
                case (funct)
                    `FN_ADDU: out.alu_op = mips_pkg::ALU_ADDU;
                    `FN_SUBU: out.alu_op = mips_pkg::ALU_SUBU;
                    `FN_AND:  out.alu_op = mips_pkg::ALU_AND;
                    `FN_OR:   out.alu_op = mips_pkg::ALU_OR;
                    `FN_XOR:  out.alu_op = mips_pkg::ALU_XOR;
                    `FN_SLT:  out.alu_op = mips_pkg::ALU_SLT;
                    default:  out.alu_op = mips_pkg::ALU_NONE;
                endcase
            end
            `OP_ADDIU: begin
                out.alu_op  = mips_pkg::ALU_ADDU;
                out.dst     = instr[20:16];
                out.use_imm = 1'b1;
            end
            `OP_ORI: begin
                // logical immediate, upper half zero
                out.alu_op   = mips_pkg::ALU_OR;
                out.dst      = instr[20:16];
                out.use_imm  = 1'b1;
                out.zero_ext = 1'b1;
            end
            `OP_LUI: begin
                out.alu_op  = mips_pkg::ALU_LUI;
                out.dst     = instr[20:16];
                out.use_imm = 1'b1;
            end
            default: begin
                out.alu_op = mips_pkg::ALU_NONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/execute.sv
`default_nettype none

module execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  mips_pkg::fetch_data_t  in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output mips_pkg::retire_data_t out_data
);

    mips_pkg::decode_data_t dec;
    mips_pkg::word_t        rs_data;
    mips_pkg::word_t        rt_data;
    mips_pkg::word_t        ext_imm;
    mips_pkg::word_t        src_b;
    mips_pkg::word_t        result;
    mips_pkg::rf_w_t        rfw;
    mips_pkg::rf_w_t        rf_wr;
    logic                   fire;

    decode decode (
        .instr (in_data.instr),
        .out   (dec)
    );

    regfile regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (dec.rs),
        .ra2   (dec.rt),
        .rd1   (rs_data),
        .rd2   (rt_data),
        .w     (rf_wr)
    );

    // one instruction per cycle while the retire queue has room
    assign in_ready  = out_ready;
    assign out_valid = in_valid;
    assign fire      = in_valid && out_ready;

    assign ext_imm = dec.zero_ext ? {16'h0000, dec.imm} : {{16{dec.imm[15]}}, dec.imm};
    assign src_b   = dec.use_imm ? ext_imm : rt_data;

    always_comb begin
        case (dec.alu_op)
            mips_pkg::ALU_ADDU: result = rs_data + src_b;
            mips_pkg::ALU_SUBU: result = rs_data - src_b;
            mips_pkg::ALU_AND:  result = rs_data & src_b;
            mips_pkg::ALU_OR:   result = rs_data | src_b;
            mips_pkg::ALU_XOR:  result = rs_data ^ src_b;
            // signed compare
            mips_pkg::ALU_SLT:  result = {31'b0, $signed(rs_data) < $signed(src_b)};
            mips_pkg::ALU_LUI:  result = {dec.imm, 16'h0000};
            default:            result = '0;
        endcase
    end

    // unknown encodings and writes to $zero retire without a write
    assign rfw.wen  = (dec.alu_op != mips_pkg::ALU_NONE) && (dec.dst != '0);
    assign rfw.addr = dec.dst;
    assign rfw.data = result;

    // the write lands at the edge ending the pop cycle
    assign rf_wr.wen  = rfw.wen && fire;
    assign rf_wr.addr = rfw.addr;
    assign rf_wr.data = rfw.data;

    assign out_data = '{pc: in_data.pc, rfw: rfw};

endmodule

`default_nettype wire

// File: rtl/fetch.sv
`default_nettype none

`include "mips_macros.svh"

module fetch (
    input  logic                  clk,
    input  logic                  rst_n,
    output mips_pkg::ibus_req_t   imem_req,
    input  mips_pkg::ibus_resp_t  imem_resp,
    output logic                  out_valid,
    input  logic                  out_ready,
    output mips_pkg::fetch_data_t out_data
);

    typedef enum logic [1:0] {
        S_REQ,
        S_WAIT,
        S_OFFER
    } state_t;

    state_t          state;
    state_t          state_next;
    logic            req_valid;
    mips_pkg::word_t pc;
    mips_pkg::word_t instr;

    always_comb begin
        state_next = state;
        case (state)
            S_REQ: begin
                if (req_valid && imem_resp.addr_ok) begin
                    state_next = S_WAIT;
                end
            end
            S_WAIT: begin
                if (imem_resp.data_ok) begin
                    state_next = S_OFFER;
                end
            end
            S_OFFER: begin
                if (out_ready) begin
                    state_next = S_REQ;
                end
            end
            default: state_next = S_REQ;
        endcase
    end

    // request valid is registered, so it stays low through the reset cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_REQ;
            req_valid <= 1'b0;
            pc        <= `RESET_PC;
        end else begin
            state     <= state_next;
            req_valid <= (state_next == S_REQ);
            if (state == S_OFFER && out_ready) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // hold the word until the queue takes it
    always_ff @(posedge clk) begin
        if (state == S_WAIT && imem_resp.data_ok) begin
            instr <= imem_resp.data;
        end
    end

    assign imem_req  = '{valid: req_valid, addr: pc};
    assign out_valid = (state == S_OFFER);
    assign out_data  = '{pc: pc, instr: instr};

endmodule

`default_nettype wire

// File: rtl/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// first fetch address after reset
`define RESET_PC 32'hbfc00000

// queue depths
`define FQ_DEPTH 4
`define RQ_DEPTH 2

// primary opcodes, instr[31:26]
`define OP_SPECIAL 6'b000000
`define OP_ADDIU   6'b001001
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111

// SPECIAL funct codes, instr[5:0]
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_SLT  6'b101010

`endif

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;

    // instruction bus request, held until addr_ok
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } ibus_resp_t;

    // fetch queue payload
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_data_t;

    typedef enum logic [2:0] {
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_NONE
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        creg_addr_t  rs;
        creg_addr_t  rt;
        creg_addr_t  dst;
        logic        use_imm;
        logic        zero_ext;
        logic [15:0] imm;
    } decode_data_t;

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      data;
    } rf_w_t;

    // one retired instruction
    typedef struct packed {
        word_t pc;
        rf_w_t rfw;
    } retire_data_t;

endpackage

`default_nettype wire

// File: rtl/pipe_fifo.sv
`default_nettype none

module pipe_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW - 1:0] wr_ptr;
    logic [AW - 1:0] rd_ptr;
    logic [CW - 1:0] count;
    logic            full;
    logic            push;
    logic            pop;

    assign full      = (count == CW'(DEPTH));
    assign out_valid = (count != '0);
    // a full queue still takes a push when the head leaves this cycle
    assign in_ready  = !full || out_ready;
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`default_nettype none

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::creg_addr_t ra1,
    input  mips_pkg::creg_addr_t ra2,
    output mips_pkg::word_t      rd1,
    output mips_pkg::word_t      rd2,
    input  mips_pkg::rf_w_t      w
);

    mips_pkg::word_t regs [32];

    // asynchronous read ports
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // $zero is never written
            if (w.wen && w.addr != '0) begin
                regs[w.addr] <= w.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# builds the datapath testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module datapath_tb -o datapath_sim
./obj_dir/datapath_sim

// File: src.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/fetch.sv
rtl/pipe_fifo.sv
rtl/decode.sv
rtl/regfile.sv
rtl/execute.sv
rtl/datapath.sv
bench/datapath_tb.sv
